// ==== rtl/icache_settings.svh ====
/*
  instruction cache geometry, shared by the packages and RTL
  include wherever a size is needed, the guard keeps it single
*/
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// base geometry
`define ICACHE_WAYS 2        // associativity
`define ICACHE_LINES 16      // lines per way, power of two
`define ICACHE_LINE_W 4      // 32-bit words per line, power of two
`define ADDR_W 32            // byte address width

// derived address split
`define ICACHE_LINE_ADDR_W $clog2(`ICACHE_LINES)
`define ICACHE_WORD_ADDR_W $clog2(`ICACHE_LINE_W)
// line and word together index one data bank
`define ICACHE_BANK_ADDR_W (`ICACHE_LINE_ADDR_W + `ICACHE_WORD_ADDR_W)
// whatever is left above line, word and byte offset
`define ICACHE_TAG_W (`ADDR_W - `ICACHE_BANK_ADDR_W - 2)

`endif

// ==== rtl/icache_pkg.sv ====
/*
  cache-side types: fetch address views, tag entry, way vector
*/
package icache_pkg;
    `include "icache_settings.svh"

    // fetch address split for tag lookup
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]       tag;
        logic [`ICACHE_LINE_ADDR_W-1:0] line;
        logic [`ICACHE_WORD_ADDR_W-1:0] word;     // word within line
        logic [1:0]                     byte_off;
    } icache_fields_t;

    // same bits seen by a data bank
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]       tag;
        logic [`ICACHE_BANK_ADDR_W-1:0] bank_addr; // {line, word}
        logic [1:0]                     byte_off;
    } icache_bank_t;

    typedef union packed {
        icache_fields_t fields;   // tag store view
        icache_bank_t   bank;     // data bank view
    } icache_addr_t;

    // one tag word per line per way
    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // one bit per way, hit and replacement vectors
    typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

endpackage

// ==== rtl/l1_bus_pkg.sv ====
/*
  L1 bus types used by the cache fill path and the memory ports
*/
package l1_bus_pkg;
    `include "icache_settings.svh"

    // one bus beat
    typedef logic [31:0] l1_word_t;

    // counts beats of a line, wraps after the last word
    typedef logic [`ICACHE_WORD_ADDR_W-1:0] beat_count_t;

endpackage

// ==== rtl/icache_ifs.sv ====
/*
  interfaces inside the cache subsystem
  fetch_sub_if joins the fetch front end to the cache
  l1_bus_if carries line requests and returning beats
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

interface fetch_sub_if import icache_pkg::*, l1_bus_pkg::*; ();
    logic         new_request;   // one-cycle pulse, only while ready
    icache_addr_t stage1_addr;   // address in the request cycle
    icache_addr_t stage2_addr;   // stage1 registered, held until next request
    l1_word_t     data_out;
    logic         data_valid;    // pulse with the fetched word
    logic         ready;         // level, cache can take a request

    modport fetch (
        output new_request, stage1_addr, stage2_addr,
        input  data_out, data_valid, ready
    );

    modport cache (
        input  new_request, stage1_addr, stage2_addr,
        output data_out, data_valid, ready
    );
endinterface

interface l1_bus_if import l1_bus_pkg::*; ();
    logic              request;     // held until ack
    logic [`ADDR_W-1:0] addr;       // line aligned
    logic              ack;
    logic              data_valid;  // one per beat, gaps allowed
    l1_word_t          data;

    modport requester (
        output request, addr,
        input  ack, data_valid, data
    );
endinterface

// ==== rtl/way_cycler.sv ====
/*
  free-running one-hot ring, cheap pseudo-random way choice for fills
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module way_cycler import icache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output way_vec_t one_hot
);

    always_ff @(posedge clk) begin
        if (rst) begin
            one_hot <= way_vec_t'(1);    // start at way 0
        end else begin
            // rotate left, top bit wraps to way 0
            one_hot <= (one_hot << 1) | way_vec_t'(one_hot[`ICACHE_WAYS-1]);
        end
    end

    // exactly one way selected every cycle
    a_one_hot : assert property (@(posedge clk) disable iff (rst) $onehot(one_hot));

endmodule

// ==== rtl/itag_banks.sv ====
/*
  per-way tag and valid store for the instruction cache
  read at stage1 on stage1_adv, compared with the stage2 tag next cycle
  walks every line after reset to clear valids, clear_done marks the end
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module itag_banks import icache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  icache_addr_t stage1_addr,
    input  icache_addr_t stage2_addr,
    input  logic         stage1_adv,    // new lookup this cycle
    input  logic         update,        // write stage2 tag as valid
    input  way_vec_t     update_way,
    output logic         tag_hit,
    output way_vec_t     tag_hit_way,
    output logic         clear_done
);

    logic [`ICACHE_LINE_ADDR_W-1:0] clear_line;   // line being invalidated

    // post-reset invalidate, one line per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_line <= '0;
            clear_done <= 1'b0;
        end else if (!clear_done) begin
            clear_line <= clear_line + 1'b1;
            clear_done <= &clear_line;   // last line written this cycle
        end
    end

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        tag_entry_t tags [`ICACHE_LINES];
        tag_entry_t rd_entry;            // entry for the current lookup

        always_ff @(posedge clk) begin
            if (!clear_done) begin
                tags[clear_line] <= '0;
            end else if (update && update_way[w]) begin
                // fill of this way, stage2 still holds the miss address
                tags[stage2_addr.fields.line] <= '{valid: 1'b1, tag: stage2_addr.fields.tag};
            end
            if (stage1_adv) begin
                rd_entry <= tags[stage1_addr.fields.line];
            end
        end

        // compare in the cycle after the read
        assign tag_hit_way[w] = rd_entry.valid && (rd_entry.tag == stage2_addr.fields.tag);
    end

    assign tag_hit = |tag_hit_way;

    // fills always replace, so a line never lives in two ways
    a_single_hit : assert property (@(posedge clk) disable iff (rst)
        $past(stage1_adv) |-> $onehot0(tag_hit_way));

endmodule

// ==== rtl/icache_data_bank.sv ====
/*
  one way of instruction data, simple dual-port word RAM
  fetch side reads with one cycle latency, fill side writes beats
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_data_bank import l1_bus_pkg::*; (
    input  logic                           clk,
    input  logic                           rd_en,
    input  logic [`ICACHE_BANK_ADDR_W-1:0] rd_addr,
    output l1_word_t                       rd_data,
    input  logic                           wr_en,
    input  logic [`ICACHE_BANK_ADDR_W-1:0] wr_addr,
    input  l1_word_t                       wr_data
);

    l1_word_t mem [`ICACHE_LINES * `ICACHE_LINE_W];   // {line, word} indexed

    // fill port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // fetch port, output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/icache.sv ====
/*
  set-associative instruction cache controller
  two-stage lookup from fetch_sub_if, line fill over the L1 bus on a miss
  target word forwarded from the fill, icache_on low sends every fetch to memory
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache import icache_pkg::*, l1_bus_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          icache_on,
    fetch_sub_if.cache   fetch_sub,
    l1_bus_if.requester  l1
);

    logic         tag_hit;
    way_vec_t     tag_hit_way;
    logic         clear_done;     // tags invalidated after reset
    logic         tag_update;     // pulse, write tag of the miss line
    way_vec_t     replacement_way;
    way_vec_t     fill_way;       // zero when the fill must not be cached
    logic         hit_allowed;    // lookup with cache on, second cycle
    logic         second_cycle;
    logic         idle;
    beat_count_t  beat_count;
    logic         is_target_word;
    logic         line_complete;
    logic         memory_complete;
    l1_word_t     miss_data;
    logic         miss_data_ready;
    icache_addr_t line_addr;
    logic [`ICACHE_BANK_ADDR_W-1:0] fill_addr;
    l1_word_t     bank_data [`ICACHE_WAYS];

    // request pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_allowed  <= 1'b0;
            second_cycle <= 1'b0;
        end else begin
            hit_allowed  <= fetch_sub.new_request & icache_on;  // sample mode per fetch
            second_cycle <= fetch_sub.new_request;
        end
    end

    // tag write one cycle after a cached miss
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_update <= 1'b0;
        end else begin
            tag_update <= second_cycle & hit_allowed & ~tag_hit;
        end
    end

    // way to fill, none when cache was off for this fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_way <= '0;
        end else if (second_cycle) begin
            fill_way <= hit_allowed ? replacement_way : '0;
        end
    end

    way_cycler i_way_cycler (
        .clk     (clk),
        .rst     (rst),
        .one_hot (replacement_way)
    );

    itag_banks i_itag_banks (
        .clk         (clk),
        .rst         (rst),
        .stage1_addr (fetch_sub.stage1_addr),
        .stage2_addr (fetch_sub.stage2_addr),
        .stage1_adv  (fetch_sub.new_request),
        .update      (tag_update),
        .update_way  (fill_way),
        .tag_hit     (tag_hit),
        .tag_hit_way (tag_hit_way),
        .clear_done  (clear_done)
    );

    // line request, raised for any fetch that is not a cached hit
    always_ff @(posedge clk) begin
        if (rst) begin
            l1.request <= 1'b0;
        end else if (second_cycle) begin
            l1.request <= ~(hit_allowed & tag_hit);
        end else if (l1.ack) begin
            l1.request <= 1'b0;
        end
    end

    // memory returns from word 0, so ask for the aligned line
    always_comb begin
        line_addr = fetch_sub.stage2_addr;
        line_addr.fields.word = '0;
        line_addr.fields.byte_off = '0;
    end
    assign l1.addr = line_addr;

    // beat counter, wraps back to 0 at end of line
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_count <= '0;
        end else if (l1.data_valid) begin
            beat_count <= beat_count + 1'b1;
        end
    end

    assign fill_addr = {fetch_sub.stage2_addr.fields.line, beat_count};

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_bank
        icache_data_bank i_data_bank (
            .clk     (clk),
            .rd_en   (fetch_sub.new_request),
            .rd_addr (fetch_sub.stage1_addr.bank.bank_addr),
            .rd_data (bank_data[w]),
            .wr_en   (fill_way[w] & l1.data_valid),
            .wr_addr (fill_addr),
            .wr_data (l1.data)
        );
    end

    // miss forwarding
    assign is_target_word = (fetch_sub.stage2_addr.fields.word == beat_count);

    always_ff @(posedge clk) begin
        if (l1.data_valid && is_target_word) begin
            miss_data <= l1.data;
        end else begin
            miss_data <= '0;    // zero so the OR below is clean
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_data_ready <= 1'b0;
        end else begin
            miss_data_ready <= l1.data_valid & is_target_word;
        end
    end

    // output word, miss data or'd with the hitting bank
    always_comb begin
        fetch_sub.data_out = miss_data;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_allowed && tag_hit_way[w]) begin
                fetch_sub.data_out = fetch_sub.data_out | bank_data[w];
            end
        end
    end

    assign fetch_sub.data_valid = miss_data_ready | (hit_allowed & tag_hit);

    // access end
    assign line_complete = l1.data_valid & (&beat_count);   // last beat

    always_ff @(posedge clk) begin
        if (rst) begin
            memory_complete <= 1'b0;
        end else begin
            memory_complete <= line_complete;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idle <= 1'b1;
        end else if (fetch_sub.new_request) begin
            idle <= 1'b0;
        end else if (memory_complete | (hit_allowed & tag_hit)) begin
            idle <= 1'b1;
        end
    end

    // held off until the tag clear is through
    assign fetch_sub.ready = clear_done & (idle | (hit_allowed & tag_hit) | memory_complete);

    // memory must ack before it returns beats
    a_no_beat_before_ack : assert property (@(posedge clk) disable iff (rst)
        (l1.request && !l1.ack) |-> !l1.data_valid);

    // no beats outside an access
    a_no_beat_when_idle : assert property (@(posedge clk) disable iff (rst)
        idle |-> !l1.data_valid);

endmodule

// ==== rtl/fetch_front.sv ====
/*
  fetch front end, one outstanding fetch at a time
  turns an accepted core request into new_request and keeps stage2
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module fetch_front import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_req,
    input  logic [`ADDR_W-1:0] fetch_addr,
    output logic               fetch_ready,
    fetch_sub_if.fetch         fetch_sub
);

    icache_addr_t stage2_addr;

    // core sees the cache ready level directly
    assign fetch_ready = fetch_sub.ready;

    // accept on req and ready, pulse lasts the accept cycle
    assign fetch_sub.new_request = fetch_req & fetch_sub.ready;
    assign fetch_sub.stage1_addr = fetch_addr;   // lookup address in cycle N

    // stage2 holds the accepted address until the next fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_addr <= '0;
        end else if (fetch_sub.new_request) begin
            stage2_addr <= fetch_addr;
        end
    end

    assign fetch_sub.stage2_addr = stage2_addr;

endmodule

// ==== rtl/icache_top.sv ====
/*
  instruction cache subsystem top, plain ports to core and memory
  fetch front end and cache joined by interfaces
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               icache_on,
    // core side
    input  logic               fetch_req,
    input  logic [`ADDR_W-1:0] fetch_addr,
    output logic               fetch_ready,
    output logic [31:0]        instr,
    output logic               instr_valid,
    // memory side
    output logic               mem_req,
    output logic [`ADDR_W-1:0] mem_addr,
    input  logic               mem_ack,
    input  logic               mem_data_valid,
    input  logic [31:0]        mem_data
);

    fetch_sub_if fetch_sub ();
    l1_bus_if    l1 ();

    fetch_front i_fetch_front (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_sub   (fetch_sub.fetch)
    );

    icache i_icache (
        .clk       (clk),
        .rst       (rst),
        .icache_on (icache_on),
        .fetch_sub (fetch_sub.cache),
        .l1        (l1.requester)
    );

    // result straight off the fetch interface
    assign instr       = fetch_sub.data_out;
    assign instr_valid = fetch_sub.data_valid;

    // L1 bus onto memory pins
    assign mem_req       = l1.request;
    assign mem_addr      = l1.addr;
    assign l1.ack        = mem_ack;
    assign l1.data_valid = mem_data_valid;
    assign l1.data       = mem_data;

endmodule

// ==== tests/icache_tb.sv ====
/*
  testbench for the instruction cache subsystem
  drives core fetches and models L1 memory with random ack delay and beat gaps
  one line per test, then a summary line
*/
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb import icache_pkg::*, l1_bus_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int N_STRESS   = 200;
    localparam int N_FETCHES  = 2 + 4 + 6 + N_STRESS;   // all tests together
    localparam int WORST_MISS = 24;   // cycles, ack wait, gapped beats, idle gap
    localparam int WATCHDOG_NS = (N_FETCHES * WORST_MISS + `ICACHE_LINES + 50) * CLK_PERIOD;

    logic               clk;
    logic               rst;
    logic               icache_on;
    logic               fetch_req;
    logic [`ADDR_W-1:0] fetch_addr;
    logic               fetch_ready;
    l1_word_t           instr;
    logic               instr_valid;
    logic               mem_req;
    logic [`ADDR_W-1:0] mem_addr;
    logic               mem_ack;
    logic               mem_data_valid;
    l1_word_t           mem_data;

    string    test_name = "";
    int       test_errors = 0;
    int       total_errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       req_rises = 0;       // mem_req rising edges seen
    logic     mem_req_q;
    l1_word_t expected_q [$];      // words owed to the core, oldest first

    icache_top i_icache_top (
        .clk            (clk),
        .rst            (rst),
        .icache_on      (icache_on),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_ready    (fetch_ready),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory contents, word address scrambled with a constant
    function automatic l1_word_t mem_word(input logic [`ADDR_W-1:0] addr);
        logic [31:0] word_addr;
        word_addr = addr >> 2;
        return (word_addr * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
    endfunction

    task automatic check_word(input string name, input l1_word_t expected, input l1_word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    // L1 memory model, one line per request
    initial begin
        logic [`ADDR_W-1:0] line_base;
        icache_addr_t       req_addr;
        mem_ack        = 1'b0;
        mem_data_valid = 1'b0;
        mem_data       = '0;
        forever begin
            @(negedge clk);
            if (mem_req === 1'b1) begin
                line_base = mem_addr;
                req_addr  = mem_addr;
                if (req_addr.fields.word != '0 || req_addr.fields.byte_off != '0) begin
                    report_failure("line request address not line aligned");
                end
                repeat ($urandom_range(3, 0)) @(negedge clk);
                mem_ack = 1'b1;             // request drops on the next edge
                @(negedge clk);
                mem_ack = 1'b0;
                for (int b = 0; b < `ICACHE_LINE_W; b++) begin
                    if ($urandom_range(1, 0) == 1) begin
                        @(negedge clk);     // gap before this beat
                    end
                    mem_data_valid = 1'b1;
                    mem_data       = mem_word(line_base + 32'(4 * b));
                    @(negedge clk);
                    mem_data_valid = 1'b0;
                end
            end
        end
    end

    // count line requests
    initial begin
        mem_req_q = 1'b0;
        forever begin
            @(negedge clk);
            if (mem_req === 1'b1 && mem_req_q !== 1'b1) begin
                req_rises++;
            end
            mem_req_q = mem_req;
        end
    end

    // compare every returned instruction with the oldest expected word
    initial begin
        forever begin
            @(negedge clk);
            if (instr_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    report_failure("instr_valid with no fetch waiting for data");
                end else begin
                    check_word(test_name, expected_q.pop_front(), instr);
                end
            end
        end
    end

    // one fetch, called at a falling edge, returns when fetch_ready is back
    task automatic do_fetch(input logic [`ADDR_W-1:0] addr, output int latency);
        int   cycles;
        int   valid_count;
        logic done;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        while (fetch_ready !== 1'b1) begin
            @(negedge clk);                 // hold req and addr
        end
        expected_q.push_back(mem_word(addr));
        @(negedge clk);                     // accepted on the edge just passed
        fetch_req   = 1'b0;
        cycles      = 1;
        valid_count = 0;
        latency     = 0;
        done        = 1'b0;
        while (!done) begin
            if (instr_valid === 1'b1) begin
                valid_count++;
                if (latency == 0) begin
                    latency = cycles;       // cycles after acceptance
                end
            end
            if (fetch_ready === 1'b1) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (valid_count != 1) begin
            report_failure("fetch did not return exactly one instruction");
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (expected_q.size() != 0) begin
            report_failure("fetches left without an instruction");
            expected_q.delete();
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int                 latency;
        int                 rises_before;
        int                 ready_cycles;
        logic               done;
        logic [`ADDR_W-1:0] off_addrs [6];
        void'($urandom(32'ha9e3));
        rst        = 1'b1;
        icache_on  = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // tag clear holds fetch off one cycle per line
        start_test("reset_state");
        ready_cycles = 0;
        done         = 1'b0;
        while (!done) begin
            @(negedge clk);
            ready_cycles++;
            if (mem_req !== 1'b0 || instr_valid !== 1'b0) begin
                report_failure("mem_req or instr_valid active after reset");
            end
            done = (fetch_ready === 1'b1) || (ready_cycles > 4 * `ICACHE_LINES);
        end
        check_count("reset_state ready cycles", `ICACHE_LINES, ready_cycles);
        end_test();

        start_test("miss_then_hit");
        rises_before = req_rises;
        do_fetch(32'h0000_1044, latency);   // line 4 word 1, cold
        check_count("miss_then_hit miss mem_req", 1, req_rises - rises_before);
        rises_before = req_rises;
        do_fetch(32'h0000_104c, latency);   // word 3 of the same line
        check_count("miss_then_hit hit mem_req", 0, req_rises - rises_before);
        check_count("miss_then_hit hit latency", 1, latency);
        end_test();

        start_test("line_reuse");
        rises_before = req_rises;
        do_fetch(32'h0000_20a8, latency);   // line 10 word 2
        for (int w = 0; w < `ICACHE_LINE_W; w++) begin
            if (w != 2) begin
                do_fetch(32'h0000_20a0 + 32'(4 * w), latency);
                check_count("line_reuse hit latency", 1, latency);
            end
        end
        check_count("line_reuse mem_req", 1, req_rises - rises_before);
        end_test();

        // repeats and already cached lines still go to memory
        start_test("cache_off");
        off_addrs = '{32'h0000_1044, 32'h0000_1044, 32'h0000_20a0,
                      32'h0000_3010, 32'h0000_3010, 32'h0000_1048};
        icache_on    = 1'b0;
        rises_before = req_rises;
        for (int i = 0; i < 6; i++) begin
            do_fetch(off_addrs[i], latency);
        end
        check_count("cache_off mem_req", 6, req_rises - rises_before);
        icache_on = 1'b1;
        end_test();

        // 64 lines over 16 sets and 2 ways, plenty of evictions
        start_test("random_stress");
        rises_before = req_rises;
        for (int i = 0; i < N_STRESS; i++) begin
            do_fetch(32'h0004_0000 + ($urandom_range(255, 0) << 2), latency);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        if (req_rises - rises_before > N_STRESS) begin
            report_failure("more line requests than fetches");
        end
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== icache_top.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/l1_bus_pkg.sv
rtl/icache_ifs.sv
rtl/way_cycler.sv
rtl/itag_banks.sv
rtl/icache_data_bank.sv
rtl/icache.sv
rtl/fetch_front.sv
rtl/icache_top.sv
tests/icache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := icache_tb
RTL_TOP    := icache_top
FILELIST   := icache_top.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run reported failure"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
